/* Makefile */
TB_TOP := tb_sample_logger

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f files.f --top-module sample_logger_top

sim:
	verilator --binary --timing -f files.f --top-module $(TB_TOP) --Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb 2>&1 | tee sim.log
	grep -q "^All tests passed!$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* common/logger_pkg.sv */
`default_nettype none

package logger_pkg;

    // one sample word as written into and read out of the FIFO
    typedef logic [7:0] data_t;

    // error tallies stick at all ones instead of wrapping
    typedef logic [7:0] err_cnt_t;

    typedef logic [3:0] burst_cnt_t;    // valid words seen in one burst

    // burst controller states
    // st_settle waits out the last registered read before the burst is reported
    typedef enum logic [1:0] {
        st_idle,
        st_read,
        st_settle
    } ctrl_state_t;

endpackage

`default_nettype wire

/* files.f */
common/logger_pkg.sv
sync_fifo/sync_fifo.sv
source/burst_ctrl.sv
source/burst_accum.sv
source/fifo_err_counter.sv
source/sample_logger_top.sv
tb/tb_sample_logger.sv

/* source/burst_accum.sv */
`timescale 1ns/1ps
`default_nettype none

module burst_accum (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    burst_start,
    input  wire                    rd_valid,
    input  wire logger_pkg::data_t rd_data,
    output logger_pkg::data_t      burst_sum,
    output logger_pkg::burst_cnt_t burst_words
);

    // results of the previous burst hold until the next burst_start
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            burst_sum   <= '0;
            burst_words <= '0;
        end else if (burst_start) begin
            // in show-ahead mode the first word can arrive with burst_start
            burst_sum   <= rd_valid ? rd_data : '0;
            burst_words <= logger_pkg::burst_cnt_t'(rd_valid);
        end else if (rd_valid) begin
            burst_sum   <= burst_sum + rd_data;    // wraps modulo 256
            burst_words <= burst_words + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* source/burst_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module burst_ctrl #(
    parameter int BURST_LEN = 4
) (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  almost_full,
    input  wire  flush,
    output logic rd_en,
    output logic burst_start,
    output logic burst_done
);

    localparam int                BEAT_W    = $clog2(BURST_LEN + 1);
    localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(BURST_LEN - 1);

    logger_pkg::ctrl_state_t state;
    logic [BEAT_W-1:0]       beat;
    logic                    flush_pend;
    logic                    af_seen;       // almost_full as sampled at the last edge
    logic                    go;

    assign go = (state == logger_pkg::st_idle) && (af_seen || flush_pend);

    assign rd_en       = (state == logger_pkg::st_read);
    assign burst_start = rd_en && (beat == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= logger_pkg::st_idle;
            beat       <= '0;
            flush_pend <= 1'b0;
            af_seen    <= 1'b0;
            burst_done <= 1'b0;
        end else begin
            af_seen    <= almost_full;
            burst_done <= (state == logger_pkg::st_settle);

            // a flush seen mid-burst stays pending and launches the next burst
            if (flush) begin
                flush_pend <= 1'b1;
            end else if (go) begin
                flush_pend <= 1'b0;
            end

            case (state)
                logger_pkg::st_idle: begin
                    if (go) begin
                        state <= logger_pkg::st_read;
                        beat  <= '0;
                    end
                end
                logger_pkg::st_read: begin
                    if (beat == LAST_BEAT) begin
                        state <= logger_pkg::st_settle;
                    end else begin
                        beat <= beat + 1'b1;
                    end
                end
                logger_pkg::st_settle: begin
                    state <= logger_pkg::st_idle;   // last read word lands in this cycle
                end
                default: begin
                    state <= logger_pkg::st_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/fifo_err_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module fifo_err_counter (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  overflow,
    input  wire                  underflow,
    output logger_pkg::err_cnt_t ovf_count,
    output logger_pkg::err_cnt_t udf_count
);

    function automatic logger_pkg::err_cnt_t sat_inc(input logger_pkg::err_cnt_t cnt);
        if (cnt == '1) begin
            return cnt;
        end
        return cnt + 1'b1;
    endfunction

    // both tallies can step in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ovf_count <= '0;
            udf_count <= '0;
        end else begin
            if (overflow) begin
                ovf_count <= sat_inc(ovf_count);
            end
            if (underflow) begin
                udf_count <= sat_inc(udf_count);
            end
        end
    end

endmodule

`default_nettype wire

/* source/sample_logger_top.sv */
`timescale 1ns/1ps
`default_nettype none

module sample_logger_top #(
    parameter int DATA_WIDTH = 8,
    parameter int FIFO_DEPTH = 16,
    parameter int ADDR_WIDTH = 4,
    parameter int BURST_LEN  = 4
) (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         wr_en,
    input  wire logger_pkg::data_t      wr_data,
    input  wire                         flush,
    output wire                         out_valid,
    output wire logger_pkg::data_t      out_data,
    output wire                         burst_done,
    output wire logger_pkg::data_t      burst_sum,
    output wire logger_pkg::burst_cnt_t burst_words,
    output wire                         full,
    output wire                         empty,
    output wire                         almost_empty,
    output wire logger_pkg::err_cnt_t   ovf_count,
    output wire logger_pkg::err_cnt_t   udf_count
);

    // a burst is launched as soon as one burst worth of words is stored
    localparam int AFULL_DEPTH = BURST_LEN;
    localparam int RDATA_MODE  = 0;

    wire almost_full;
    wire rd_en;
    wire burst_start;
    wire overflow;
    wire underflow;

    sync_fifo #(
        .DATA_WIDTH  (DATA_WIDTH),
        .FIFO_DEPTH  (FIFO_DEPTH),
        .AFULL_DEPTH (AFULL_DEPTH),
        .ADDR_WIDTH  (ADDR_WIDTH),
        .RDATA_MODE  (RDATA_MODE)
    ) u_fifo (
        .clk          (clk),
        .rst_n        (rst_n),
        .wr_en        (wr_en),
        .wr_data      (wr_data),
        .rd_en        (rd_en),
        .rd_data      (out_data),
        .rd_valid     (out_valid),
        .full         (full),
        .empty        (empty),
        .almost_full  (almost_full),
        .almost_empty (almost_empty),
        .overflow     (overflow),
        .underflow    (underflow)
    );

    burst_ctrl #(
        .BURST_LEN (BURST_LEN)
    ) u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .almost_full (almost_full),
        .flush       (flush),
        .rd_en       (rd_en),
        .burst_start (burst_start),
        .burst_done  (burst_done)
    );

    burst_accum u_accum (
        .clk         (clk),
        .rst_n       (rst_n),
        .burst_start (burst_start),
        .rd_valid    (out_valid),
        .rd_data     (out_data),
        .burst_sum   (burst_sum),
        .burst_words (burst_words)
    );

    fifo_err_counter u_err (
        .clk       (clk),
        .rst_n     (rst_n),
        .overflow  (overflow),
        .underflow (underflow),
        .ovf_count (ovf_count),
        .udf_count (udf_count)
    );

endmodule

`default_nettype wire

/* sync_fifo/sync_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter int DATA_WIDTH  = 8,
    parameter int FIFO_DEPTH  = 16,
    parameter int AFULL_DEPTH = FIFO_DEPTH - 1,
    parameter int ADDR_WIDTH  = 4,
    parameter int RDATA_MODE  = 0
) (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    wr_en,
    input  wire logger_pkg::data_t wr_data,
    input  wire                    rd_en,
    output logger_pkg::data_t      rd_data,
    output logic                   rd_valid,
    output logic                   full,
    output logic                   empty,
    output logic                   almost_full,
    output logic                   almost_empty,
    output logic                   overflow,
    output logic                   underflow
);

    localparam logic [ADDR_WIDTH-1:0] LAST_ADDR = ADDR_WIDTH'(FIFO_DEPTH - 1);
    localparam logic [ADDR_WIDTH:0]   FULL_LVL  = (ADDR_WIDTH + 1)'(FIFO_DEPTH);
    localparam logic [ADDR_WIDTH:0]   AF_LVL    = (ADDR_WIDTH + 1)'(AFULL_DEPTH);
    localparam logic [ADDR_WIDTH:0]   AE_LVL    = (ADDR_WIDTH + 1)'(1);

    logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH];
    logic [ADDR_WIDTH-1:0] wr_ptr;
    logic [ADDR_WIDTH-1:0] rd_ptr;
    logic [ADDR_WIDTH:0]   fill_cnt;    // one bit wider than the pointers so full fits
    logic                  wr_ok;
    logic                  rd_ok;

    assign wr_ok = wr_en && !full;
    assign rd_ok = rd_en && !empty;

    assign full         = (fill_cnt == FULL_LVL);
    assign empty        = (fill_cnt == '0);
    assign almost_full  = (fill_cnt >= AF_LVL);
    assign almost_empty = (fill_cnt <= AE_LVL);

    // pointers move only on accepted operations and wrap at the last entry
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= (wr_ptr == LAST_ADDR) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= (rd_ptr == LAST_ADDR) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fill_cnt <= '0;
        end else begin
            case ({wr_ok, rd_ok})
                2'b10:   fill_cnt <= fill_cnt + 1'b1;
                2'b01:   fill_cnt <= fill_cnt - 1'b1;
                default: fill_cnt <= fill_cnt;  // idle, or read and write together
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // rejected requests show up one cycle later as single-cycle pulses
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            overflow  <= 1'b0;
            underflow <= 1'b0;
        end else begin
            overflow  <= wr_en && full;
            underflow <= rd_en && empty;
        end
    end

    generate
        if (RDATA_MODE == 0) begin : g_reg_read
            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    rd_valid <= 1'b0;
                end else begin
                    rd_valid <= rd_ok;
                end
            end

            always_ff @(posedge clk) begin
                if (rd_ok) begin
                    rd_data <= mem[rd_ptr];
                end
            end
        end else begin : g_ahead_read
            // show-ahead, the head word is visible before the read strobe
            assign rd_data  = mem[rd_ptr];
            assign rd_valid = rd_ok;
        end
    endgenerate

endmodule

`default_nettype wire

/* tb/tb_sample_logger.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_sample_logger;

    localparam int CLK_PERIOD      = 40;
    localparam int DRIVE_DLY       = 2;
    localparam int RESET_CYCLES    = 5;
    localparam int FIFO_DEPTH      = 16;
    localparam int BURST_LEN       = 4;
    localparam int OVF_WRITES      = 3 * FIFO_DEPTH + 3;  // enough to outrun the burst drain
    localparam int MIX_CYCLES      = 300;
    localparam int TEST_CYCLES     = RESET_CYCLES + 80 + OVF_WRITES + MIX_CYCLES;
    localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES + 200;

    logic                   clk;
    logic                   rst_n;
    logic                   wr_en;
    logger_pkg::data_t      wr_data;
    logic                   flush;
    logic                   out_valid;
    logger_pkg::data_t      out_data;
    logic                   burst_done;
    logger_pkg::data_t      burst_sum;
    logger_pkg::burst_cnt_t burst_words;
    logic                   full;
    logic                   empty;
    logic                   almost_empty;
    logger_pkg::err_cnt_t   ovf_count;
    logger_pkg::err_cnt_t   udf_count;

    // reference model of the stored words, the burst controller and the counters
    logger_pkg::data_t       q[$];
    logger_pkg::ctrl_state_t m_state;
    int                      m_beat;
    logic                    m_pend;
    logic                    m_af;
    logic                    exp_valid;
    logger_pkg::data_t       exp_data;
    logic                    exp_done;
    logger_pkg::data_t       acc_sum;
    int                      acc_words;
    logic                    ovf_p;
    logic                    udf_p;
    int                      ovf_cnt;
    int                      udf_cnt;
    int                      cyc;
    logic [31:0]             lfsr;
    string                   cur_test;

    sample_logger_top #(
        .DATA_WIDTH (8),
        .FIFO_DEPTH (FIFO_DEPTH),
        .ADDR_WIDTH (4),
        .BURST_LEN  (BURST_LEN)
    ) UUT (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic lfsr_bit();
        logic b;
        b    = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ 32'h80200003;
        end
        return b;
    endfunction

    function automatic logic [7:0] lfsr_bits(input int n);
        logic [7:0] v;
        v = 8'h00;
        for (int i = 0; i < n; i++) begin
            v = {v[6:0], lfsr_bit()};
        end
        return v;
    endfunction

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_val(input string what, input int exp, input int act);
        assert (exp == act) else stop_run($sformatf("[ERROR] %s: %s expected %0d actual %0d",
                                                    cur_test, what, exp, act));
    endtask

    // the model sees the same inputs as the DUT at each rising edge
    always @(posedge clk) begin
        int   cnt;
        logic rd;
        logic go;
        cyc = cyc + 1;
        if (!rst_n) begin
            q.delete();
            m_state   = logger_pkg::st_idle;
            m_beat    = 0;
            m_pend    = 1'b0;
            m_af      = 1'b0;
            exp_valid = 1'b0;
            exp_done  = 1'b0;
            acc_sum   = 8'h00;
            acc_words = 0;
            ovf_p     = 1'b0;
            udf_p     = 1'b0;
            ovf_cnt   = 0;
            udf_cnt   = 0;
        end else begin
            cnt = q.size();
            rd  = (m_state == logger_pkg::st_read);
            go  = (m_state == logger_pkg::st_idle) && (m_af || m_pend);
            if (rd && m_beat == 0) begin
                acc_sum   = 8'h00;
                acc_words = 0;
            end else if (exp_valid) begin
                acc_sum   = acc_sum + exp_data;    // modulo 256 by width
                acc_words = acc_words + 1;
            end
            if (ovf_p && ovf_cnt < 255) ovf_cnt++;
            if (udf_p && udf_cnt < 255) udf_cnt++;
            ovf_p     = wr_en && (cnt == FIFO_DEPTH);
            udf_p     = rd && (cnt == 0);
            exp_done  = (m_state == logger_pkg::st_settle);
            exp_valid = rd && (cnt > 0);
            if (exp_valid) exp_data = q.pop_front();
            if (wr_en && cnt < FIFO_DEPTH) q.push_back(wr_data);
            if (flush) begin
                m_pend = 1'b1;
            end else if (go) begin
                m_pend = 1'b0;
            end
            m_af = (cnt >= BURST_LEN);
            if (go) begin
                m_state = logger_pkg::st_read;
                m_beat  = 0;
            end else if (rd && m_beat == BURST_LEN - 1) begin
                m_state = logger_pkg::st_settle;
            end else if (rd) begin
                m_beat++;
            end else if (m_state == logger_pkg::st_settle) begin
                m_state = logger_pkg::st_idle;
            end
        end
    end

    // outputs are compared at the falling edge where they are stable
    always @(negedge clk) begin
        if (rst_n) begin
            check_val("out_valid", int'(exp_valid), int'(out_valid));
            if (exp_valid) check_val("out_data", int'(exp_data), int'(out_data));
            check_val($sformatf("burst_done in %s", m_state.name()), int'(exp_done),
                      int'(burst_done));
            if (exp_done) begin
                check_val("burst_words", acc_words, int'(burst_words));
                check_val("burst_sum", int'(acc_sum), int'(burst_sum));
            end
            check_val("full", int'(q.size() == FIFO_DEPTH), int'(full));
            check_val("empty", int'(q.size() == 0), int'(empty));
            check_val("almost_empty", int'(q.size() <= 1), int'(almost_empty));
            check_val("ovf_count", ovf_cnt, int'(ovf_count));
            check_val("udf_count", udf_cnt, int'(udf_count));
        end
    end

    task automatic drive(input logic w, input logger_pkg::data_t d, input logic f);
        @(posedge clk);
        #DRIVE_DLY;
        wr_en   = w;
        wr_data = d;
        flush   = f;
    endtask

    task automatic wait_burst_done(input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (!burst_done && n < limit) begin
            @(negedge clk);
            n++;
        end
        assert (burst_done) else stop_run({cur_test, ": burst_done never arrived"});
    endtask

    task automatic wait_model_idle(input int limit);
        int n;
        n = 0;
        while ((m_state != logger_pkg::st_idle || m_pend || m_af || q.size() >= BURST_LEN)
               && n < limit) begin
            drive(1'b0, 8'h00, 1'b0);
            n++;
        end
        assert (n < limit) else stop_run({cur_test, ": bursts kept running after the writes"});
        repeat (3) drive(1'b0, 8'h00, 1'b0);    // last report and error counts settle
    endtask

    task automatic test_after_reset();
        cur_test = "after_reset";
        @(negedge clk);
        check_val("empty", 1, int'(empty));
        check_val("almost_empty", 1, int'(almost_empty));
        check_val("full", 0, int'(full));
        check_val("out_valid", 0, int'(out_valid));
        check_val("ovf_count", 0, int'(ovf_count));
        check_val("udf_count", 0, int'(udf_count));
    endtask

    task automatic test_auto_burst();
        logger_pkg::data_t d;
        logger_pkg::data_t sum;
        int                wr_edge;
        int                n;
        cur_test = "auto_burst";
        sum      = 8'h00;
        for (int i = 0; i < BURST_LEN; i++) begin
            d   = lfsr_bits(8);
            sum = sum + d;
            drive(1'b1, d, 1'b0);
        end
        drive(1'b0, 8'h00, 1'b0);
        wr_edge = cyc;  // the last write is taken at this edge
        n       = 0;
        @(negedge clk);
        while (!out_valid && n < 10) begin
            @(negedge clk);
            n++;
        end
        check_val("first out_valid latency", 3, cyc - wr_edge);
        wait_burst_done(12);
        check_val("burst_words", BURST_LEN, int'(burst_words));
        check_val("burst_sum", int'(sum), int'(burst_sum));
    endtask

    task automatic test_short_flush();
        int udf0;
        cur_test = "short_flush";
        udf0     = int'(udf_count);
        drive(1'b1, lfsr_bits(8), 1'b0);
        drive(1'b1, lfsr_bits(8), 1'b0);
        drive(1'b0, 8'h00, 1'b1);
        drive(1'b0, 8'h00, 1'b0);
        wait_burst_done(12);
        check_val("burst_words", 2, int'(burst_words));
        repeat (2) drive(1'b0, 8'h00, 1'b0);
        check_val("udf_count rise", 2, int'(udf_count) - udf0);
        check_val("empty", 1, int'(empty));
    endtask

    task automatic test_overflow();
        int ovf0;
        int dropped;
        cur_test = "overflow";
        ovf0     = int'(ovf_count);
        dropped  = 0;
        for (int i = 0; i < OVF_WRITES; i++) begin
            drive(1'b1, lfsr_bits(8), 1'b0);
            // the model count here is the one this write meets at the next edge
            if (q.size() == FIFO_DEPTH) dropped++;
        end
        drive(1'b0, 8'h00, 1'b0);
        wait_model_idle(80);
        assert (dropped > 0) else stop_run("overflow: the FIFO never filled up");
        check_val("ovf_count rise", dropped, int'(ovf_count) - ovf0);
        drive(1'b0, 8'h00, 1'b1);
        drive(1'b0, 8'h00, 1'b0);
        wait_burst_done(12);
    endtask

    task automatic test_mixed_traffic();
        logic              w;
        logger_pkg::data_t d;
        logic              f;
        cur_test = "mixed_traffic";
        for (int i = 0; i < MIX_CYCLES; i++) begin
            w = lfsr_bit();
            d = lfsr_bits(8);
            f = (lfsr_bits(4) == 8'h00);
            drive(w, d, f);
        end
        drive(1'b0, 8'h00, 1'b0);
        wait_model_idle(80);
    endtask

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        wr_en    = 1'b0;
        wr_data  = 8'h00;
        flush    = 1'b0;
        lfsr     = 32'hdfd1;
        cyc      = 0;
        cur_test = "reset";
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        test_after_reset();
        test_auto_burst();
        test_short_flush();
        test_overflow();
        test_mixed_traffic();
        $display("All tests passed!");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        stop_run("watchdog expired before the tests finished");
    end

endmodule

`default_nettype wire
